// File: rtl/mbox_cfg.svh
`ifndef MBOX_CFG_SVH
`define MBOX_CFG_SVH

// Word address on the memory bus
`define MBOX_ADR_W 14

// One request bit per quadword word
`define MBOX_RQ_W 4

// Wishbone data path width
`define MBOX_WB_DAT_W 16

// Clock cycles in each A or B phase
`define MBOX_PHASE_CYCLES 4

// Eight diagnostic words
`define MBOX_DIAG_SEL_W 3

`endif

// File: rtl/mboxPkg.sv
`include "mbox_cfg.svh"

package mboxPkg;

  // One request as held on the memory bus
  typedef struct packed {
    logic [`MBOX_ADR_W-1:0] adr;
    logic [`MBOX_RQ_W-1:0] rq;
    logic rd;
    logic wr;
    logic forceBadPar;
  } memRequestT;

  typedef enum logic {
    phaseA = 1'b0,
    phaseB = 1'b1
  } busPhaseT;

  // Returned on Wishbone read data when the cycle ends
  typedef struct packed {
    logic nxm;
    logic [2:0] wordCount;
    busPhaseT startPhase;
  } reqStatusT;

  typedef logic [15:0] diagWordT;

endpackage

// File: rtl/memReqIf.sv
`timescale 1ns/10ps

interface memReqIf;

  mboxPkg::memRequestT request;
  logic reqHold;
  logic memStartA;
  logic memStartB;
  logic lastAcknSeen;
  logic nxmSeen;

  // Start logic owns the held request
  modport source(
    output request, reqHold, memStartA, memStartB, lastAcknSeen, nxmSeen
  );

  modport sink(
    input request, reqHold, memStartA, memStartB, lastAcknSeen, nxmSeen
  );

  modport monitor(
    input request, reqHold, memStartA, memStartB, lastAcknSeen, nxmSeen
  );

endinterface

// File: rtl/phaseClock.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module phaseClock (
  input  logic clk,
  input  logic reset,
  output mboxPkg::busPhaseT phase,
  output logic aChangeComing,
  output logic bChangeComing
);

  localparam int cntW = $clog2(`MBOX_PHASE_CYCLES);

  logic [cntW-1:0] count;
  logic lastCycle;

  assign lastCycle = (count == cntW'(`MBOX_PHASE_CYCLES - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      phase <= mboxPkg::phaseA;
    end else if (lastCycle) begin
      count <= '0;
      phase <= (phase == mboxPkg::phaseA) ? mboxPkg::phaseB : mboxPkg::phaseA;
    end else begin
      count <= count + 1'b1;
    end
  end

  // Strobe names the phase about to begin
  assign aChangeComing = lastCycle && (phase == mboxPkg::phaseB);
  assign bChangeComing = lastCycle && (phase == mboxPkg::phaseA);

endmodule

// File: rtl/memStart.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module memStart (
  input  logic clk,
  input  logic reset,
  input  logic wbCyc,
  input  logic wbStb,
  input  logic wbWe,
  input  logic [`MBOX_ADR_W-1:0] wbAdr,
  input  logic [`MBOX_WB_DAT_W-1:0] wbDatIn,
  output logic acknWr,
  input  mboxPkg::busPhaseT phase,
  input  logic aChangeComing,
  input  logic bChangeComing,
  input  logic memAcknA,
  input  logic memAcknB,
  input  logic nxmAckn,
  input  logic readDone,
  memReqIf.source req,
  output logic [`MBOX_ADR_W-1:0] memAdr,
  output logic [`MBOX_RQ_W-1:0] memRq,
  output logic memRdRq,
  output logic memWrRq,
  output logic memAdrPar
);

  mboxPkg::busPhaseT nextPhase;
  logic [`MBOX_RQ_W-1:0] rqLeft;
  logic [`MBOX_RQ_W-1:0] rqLeftNext;
  logic anyStart, anyChangeComing, takeReq, setStart, clrStart;
  logic acknPulse, nxmPulse, lastAckn, startClrd;
  logic busValid;

  assign anyStart = req.memStartA || req.memStartB;
  assign anyChangeComing = aChangeComing || bChangeComing;
  assign nextPhase = (phase == mboxPkg::phaseA) ? mboxPkg::phaseB : mboxPkg::phaseA;

  // Busy until the bus side is quiet as well
  assign takeReq = wbCyc && wbStb && !req.reqHold && !anyStart;
  assign setStart = req.reqHold && !anyStart && !req.lastAcknSeen && anyChangeComing;
  assign clrStart = anyStart && anyChangeComing && req.lastAcknSeen;

  assign acknPulse = !req.lastAcknSeen &&
                     ((memAcknA && aChangeComing && req.memStartA) ||
                      (memAcknB && bChangeComing && req.memStartB));
  assign nxmPulse = !req.lastAcknSeen && nxmAckn &&
                    ((aChangeComing && req.memStartA) || (bChangeComing && req.memStartB));

  // Drop the lowest remaining word
  assign rqLeftNext = rqLeft & (rqLeft - 1'b1);
  assign lastAckn = acknPulse && (rqLeftNext == '0);

  always_ff @(posedge clk) begin
    if (takeReq) begin
      req.request.adr <= wbAdr;
      req.request.rq <= wbDatIn[`MBOX_RQ_W-1:0];
      req.request.rd <= !wbWe;
      req.request.wr <= wbWe;
      req.request.forceBadPar <= wbDatIn[`MBOX_RQ_W];
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      req.reqHold <= 1'b0;
      req.memStartA <= 1'b0;
      req.memStartB <= 1'b0;
      req.lastAcknSeen <= 1'b0;
      req.nxmSeen <= 1'b0;
      rqLeft <= '0;
      startClrd <= 1'b0;
      acknWr <= 1'b0;
    end else begin
      startClrd <= clrStart;
      acknWr <= startClrd && req.request.wr;
      if (takeReq) begin
        req.reqHold <= 1'b1;
        req.lastAcknSeen <= 1'b0;
        req.nxmSeen <= 1'b0;
        rqLeft <= wbDatIn[`MBOX_RQ_W-1:0];
      end else if (acknWr || readDone) begin
        req.reqHold <= 1'b0;
      end
      if (setStart) begin
        req.memStartA <= (nextPhase == mboxPkg::phaseA);
        req.memStartB <= (nextPhase == mboxPkg::phaseB);
      end else if (clrStart) begin
        req.memStartA <= 1'b0;
        req.memStartB <= 1'b0;
      end
      if (nxmPulse) begin
        req.nxmSeen <= 1'b1;
        req.lastAcknSeen <= 1'b1;
        rqLeft <= '0;
      end else if (acknPulse) begin
        rqLeft <= rqLeftNext;
        req.lastAcknSeen <= lastAckn;
      end
    end
  end

  // Fields stay on the bus until start drops
  assign busValid = req.reqHold || anyStart;

  assign memAdr = busValid ? req.request.adr : '0;
  assign memRq = busValid ? req.request.rq : '0;
  assign memRdRq = busValid && req.request.rd;
  assign memWrRq = busValid && req.request.wr;

  // Odd parity, flipped on request for diagnostics
  assign memAdrPar = busValid &&
                     (~(^{memAdr, memRq, memRdRq, memWrRq}) ^ req.request.forceBadPar);

endmodule

// File: rtl/coreReadTracker.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module coreReadTracker (
  input  logic clk,
  input  logic reset,
  memReqIf.sink req,
  input  logic aChangeComing,
  input  logic bChangeComing,
  input  logic memDataValidA,
  input  logic memDataValidB,
  output logic readDone,
  output mboxPkg::reqStatusT status
);

  mboxPkg::busPhaseT startPhase;
  logic [2:0] wordsWanted;
  logic [2:0] wordCount;
  logic started, readActive, readEnd;
  logic dvMinus2, dvMinus1, coreDataValid;

  always_comb begin
    wordsWanted = '0;
    for (int i = 0; i < `MBOX_RQ_W; i++) begin
      wordsWanted = wordsWanted + 3'(req.request.rq[i]);
    end
  end

  assign readActive = req.reqHold && req.request.rd && started;

  // Data valid only counts on the strobe of the started phase
  assign dvMinus2 = readActive &&
                    ((startPhase == mboxPkg::phaseA) ? (memDataValidA && aChangeComing) :
                                                      (memDataValidB && bChangeComing));

  assign readEnd = req.reqHold && req.request.rd &&
                   (req.nxmSeen || (started && wordCount == wordsWanted));

  always_ff @(posedge clk) begin
    if (reset) begin
      started <= 1'b0;
      startPhase <= mboxPkg::phaseA;
      dvMinus1 <= 1'b0;
      coreDataValid <= 1'b0;
      wordCount <= '0;
      readDone <= 1'b0;
    end else begin
      dvMinus1 <= dvMinus2;
      coreDataValid <= dvMinus1;
      readDone <= readEnd && !readDone;
      if (!req.reqHold) begin
        started <= 1'b0;
        wordCount <= '0;
      end else begin
        if (!started && (req.memStartA || req.memStartB)) begin
          started <= 1'b1;
          startPhase <= req.memStartB ? mboxPkg::phaseB : mboxPkg::phaseA;
        end
        if (coreDataValid) begin
          wordCount <= wordCount + 1'b1;
        end
      end
    end
  end

  assign status = '{nxm: req.nxmSeen, wordCount: wordCount, startPhase: startPhase};

endmodule

// File: rtl/diagMux.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module diagMux (
  input  logic clk,
  input  logic reset,
  memReqIf.monitor req,
  input  mboxPkg::busPhaseT phase,
  input  logic [`MBOX_DIAG_SEL_W-1:0] diagSel,
  output mboxPkg::diagWordT diagData
);

  logic [`MBOX_ADR_W-1:0] snapAdr;
  logic [`MBOX_RQ_W-1:0] snapRq;
  logic snapStartA, snapStartB, snapPhase, snapLast, snapNxm;

  // Snapshot follows the request and then freezes
  always_ff @(posedge clk) begin
    if (req.reqHold) begin
      snapAdr <= req.request.adr;
      snapRq <= req.request.rq;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      snapStartA <= 1'b0;
      snapStartB <= 1'b0;
      snapPhase <= 1'b0;
      snapLast <= 1'b0;
      snapNxm <= 1'b0;
    end else if (req.reqHold) begin
      snapStartA <= req.memStartA;
      snapStartB <= req.memStartB;
      snapPhase <= (phase == mboxPkg::phaseB);
      snapLast <= req.lastAcknSeen;
      snapNxm <= req.nxmSeen;
    end
  end

  always_comb begin
    case (diagSel)
      `MBOX_DIAG_SEL_W'(0): diagData = mboxPkg::diagWordT'(snapAdr);
      `MBOX_DIAG_SEL_W'(1): diagData = mboxPkg::diagWordT'(snapRq);
      `MBOX_DIAG_SEL_W'(2): diagData = {13'b0, snapStartA, snapStartB, snapPhase};
      `MBOX_DIAG_SEL_W'(3): diagData = {14'b0, snapLast, snapNxm};
      default: diagData = '0;
    endcase
  end

endmodule

// File: rtl/mboxControl.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module mboxControl (
  input  logic clk,
  input  logic reset,
  input  logic wbCyc,
  input  logic wbStb,
  input  logic wbWe,
  input  logic [`MBOX_ADR_W-1:0] wbAdr,
  input  logic [`MBOX_WB_DAT_W-1:0] wbDatIn,
  output logic [`MBOX_WB_DAT_W-1:0] wbDatOut,
  output logic wbAck,
  output logic memStartA,
  output logic memStartB,
  output logic [`MBOX_ADR_W-1:0] memAdr,
  output logic [`MBOX_RQ_W-1:0] memRq,
  output logic memRdRq,
  output logic memWrRq,
  output logic memAdrPar,
  input  logic memAcknA,
  input  logic memAcknB,
  input  logic nxmAckn,
  input  logic memDataValidA,
  input  logic memDataValidB,
  input  logic [`MBOX_DIAG_SEL_W-1:0] diagSel,
  output mboxPkg::diagWordT diagData
);

  mboxPkg::busPhaseT phase;
  mboxPkg::reqStatusT status;
  logic aChangeComing, bChangeComing, acknWr, readDone;

  memReqIf req();

  phaseClock phaseClock_inst (
    .clk(clk), .reset(reset), .phase(phase),
    .aChangeComing(aChangeComing), .bChangeComing(bChangeComing)
  );

  memStart memStart_inst (
    .clk(clk), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
    .wbAdr(wbAdr), .wbDatIn(wbDatIn), .acknWr(acknWr), .phase(phase),
    .aChangeComing(aChangeComing), .bChangeComing(bChangeComing),
    .memAcknA(memAcknA), .memAcknB(memAcknB), .nxmAckn(nxmAckn),
    .readDone(readDone), .req(req.source), .memAdr(memAdr), .memRq(memRq),
    .memRdRq(memRdRq), .memWrRq(memWrRq), .memAdrPar(memAdrPar)
  );

  coreReadTracker coreReadTracker_inst (
    .clk(clk), .reset(reset), .req(req.sink),
    .aChangeComing(aChangeComing), .bChangeComing(bChangeComing),
    .memDataValidA(memDataValidA), .memDataValidB(memDataValidB),
    .readDone(readDone), .status(status)
  );

  diagMux diagMux_inst (
    .clk(clk), .reset(reset), .req(req.monitor), .phase(phase),
    .diagSel(diagSel), .diagData(diagData)
  );

  assign memStartA = req.memStartA;
  assign memStartB = req.memStartB;

  // One ack per request, from whichever side finished it
  assign wbAck = acknWr || readDone;
  assign wbDatOut = `MBOX_WB_DAT_W'(status);

endmodule

// File: tb/mboxChecker.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module mboxChecker (
  input  logic clk,
  input  logic reset,
  input  logic [63:0] testName,
  input  logic testRead,
  input  logic [`MBOX_ADR_W-1:0] testAdr,
  input  logic [`MBOX_RQ_W-1:0] testMask,
  input  logic testBadPar,
  input  logic testNxm,
  input  logic [2:0] testWords,
  input  logic diagCheck,
  input  logic wbCyc,
  input  logic wbStb,
  input  logic wbAck,
  input  logic [`MBOX_WB_DAT_W-1:0] wbDatOut,
  input  logic memStartA,
  input  logic memStartB,
  input  logic [`MBOX_ADR_W-1:0] memAdr,
  input  logic [`MBOX_RQ_W-1:0] memRq,
  input  logic memRdRq,
  input  logic memWrRq,
  input  logic memAdrPar,
  input  logic [`MBOX_DIAG_SEL_W-1:0] diagSel,
  input  mboxPkg::diagWordT diagData,
  output int valueErrors,
  output int protocolErrors
);

  int busCycle;
  logic prevStartA, prevStartB, startPhaseSeen;

  initial begin
    valueErrors = 0;
    protocolErrors = 0;
  end

  // Odd parity bit over any set of fields, zero padded
  function automatic logic oddParityBit(input logic [31:0] bits);
    int ones;
    ones = 0;
    for (int i = 0; i < 32; i++) begin
      ones += bits[i];
    end
    return (ones % 2 == 0);
  endfunction

  function automatic logic [31:0] expectedDiag(input logic [`MBOX_DIAG_SEL_W-1:0] sel);
    case (sel)
      0: return 32'(testAdr);
      1: return 32'(testMask);
      3: return {30'b0, 1'b1, testNxm};
      default: return 32'b0;
    endcase
  endfunction

  task automatic checkValue(input logic [8*12-1:0] what, input logic [31:0] expected,
                            input logic [31:0] actual);
    if (expected !== actual) begin
      valueErrors++;
      $display("FAIL %0s: %0s expected %0h, actual %0h", testName, what, expected, actual);
    end
  endtask

  task automatic reportProblem(input logic [8*48-1:0] msg);
    protocolErrors++;
    $display("Error in %0s: %0s", testName, msg);
  endtask

  always @(negedge clk) begin
    if (reset) begin
      busCycle = 0;
      prevStartA = 1'b0;
      prevStartB = 1'b0;
      startPhaseSeen = 1'b0;
    end else begin
      if (memStartA && memStartB) begin
        reportProblem("memStartA and memStartB high together");
      end
      // Phase A opens at cycle 0 of each 8, phase B at cycle 4
      if (memStartA && !prevStartA) begin
        startPhaseSeen = 1'b0;
        if (busCycle % 8 != 0) begin
          reportProblem("memStartA rose outside the change to phase A");
        end
      end
      if (memStartB && !prevStartB) begin
        startPhaseSeen = 1'b1;
        if (busCycle % 8 != 4) begin
          reportProblem("memStartB rose outside the change to phase B");
        end
      end
      if (memStartA || memStartB) begin
        checkValue("memAdr", testAdr, memAdr);
        checkValue("memRq", testMask, memRq);
        checkValue("memRdRq", testRead, memRdRq);
        checkValue("memWrRq", !testRead, memWrRq);
        checkValue("memAdrPar",
                   oddParityBit({testAdr, testMask, testRead, !testRead}) ^ testBadPar,
                   memAdrPar);
      end
      if (wbAck) begin
        if (!(wbCyc && wbStb)) begin
          reportProblem("wbAck seen with no request pending");
        end
        checkValue("wbDatOut", {testNxm, testWords, startPhaseSeen}, wbDatOut);
      end
      if (diagCheck) begin
        checkValue("diagData", expectedDiag(diagSel), diagData);
      end
      prevStartA = memStartA;
      prevStartB = memStartB;
      busCycle++;
    end
  end

endmodule

// File: tb/mboxControlTb.sv
`timescale 1ns/10ps
`include "mbox_cfg.svh"

module mboxControlTb;

  typedef struct packed {
    logic [63:0] name;
    logic rd;
    logic [`MBOX_ADR_W-1:0] adr;
    logic [`MBOX_RQ_W-1:0] mask;
    logic badPar;
    logic nxm;
    logic [`MBOX_DIAG_SEL_W-1:0] sel;
    logic [2:0] words;
  } testEntryT;

  localparam int numTests = 9;
  localparam int resetCycles = 10;
  localparam int cycleLimit = numTests * 60 + resetCycles;

  logic clk, reset, wbCyc, wbStb, wbWe, wbAck;
  logic [`MBOX_ADR_W-1:0] wbAdr, memAdr;
  logic [`MBOX_WB_DAT_W-1:0] wbDatIn, wbDatOut;
  logic memStartA, memStartB, memRdRq, memWrRq, memAdrPar;
  logic [`MBOX_RQ_W-1:0] memRq;
  logic memAcknA, memAcknB, nxmAckn, memDataValidA, memDataValidB;
  logic [`MBOX_DIAG_SEL_W-1:0] diagSel;
  mboxPkg::diagWordT diagData;
  logic diagCheck;
  int valueErrors, protocolErrors;
  testEntryT tests [0:numTests-1];
  testEntryT cur;
  integer seed;
  int testCount = 0;
  int busCycle = 0;
  int cycleCount = 0;
  int respLeft = 0;
  logic respPrevA = 1'b0;
  logic respPrevB = 1'b0;

  mboxControl mboxControl_inst (
    .clk(clk), .reset(reset), .wbCyc(wbCyc), .wbStb(wbStb), .wbWe(wbWe),
    .wbAdr(wbAdr), .wbDatIn(wbDatIn), .wbDatOut(wbDatOut), .wbAck(wbAck),
    .memStartA(memStartA), .memStartB(memStartB), .memAdr(memAdr), .memRq(memRq),
    .memRdRq(memRdRq), .memWrRq(memWrRq), .memAdrPar(memAdrPar),
    .memAcknA(memAcknA), .memAcknB(memAcknB), .nxmAckn(nxmAckn),
    .memDataValidA(memDataValidA), .memDataValidB(memDataValidB),
    .diagSel(diagSel), .diagData(diagData)
  );

  mboxChecker mboxChecker_inst (
    .clk(clk), .reset(reset), .testName(cur.name), .testRead(cur.rd),
    .testAdr(cur.adr), .testMask(cur.mask), .testBadPar(cur.badPar),
    .testNxm(cur.nxm), .testWords(cur.words), .diagCheck(diagCheck),
    .wbCyc(wbCyc), .wbStb(wbStb), .wbAck(wbAck), .wbDatOut(wbDatOut),
    .memStartA(memStartA), .memStartB(memStartB), .memAdr(memAdr), .memRq(memRq),
    .memRdRq(memRdRq), .memWrRq(memWrRq), .memAdrPar(memAdrPar),
    .diagSel(diagSel), .diagData(diagData),
    .valueErrors(valueErrors), .protocolErrors(protocolErrors)
  );

  always #5 clk = ~clk;

  function automatic int countBits(input logic [`MBOX_RQ_W-1:0] bits);
    int ones;
    ones = 0;
    for (int i = 0; i < `MBOX_RQ_W; i++) begin
      ones += bits[i];
    end
    return ones;
  endfunction

  task automatic addEntry(input logic [63:0] name, input logic rd,
                          input logic [`MBOX_RQ_W-1:0] mask, input logic badPar,
                          input logic nxm, input logic [`MBOX_DIAG_SEL_W-1:0] sel,
                          input logic [2:0] words);
    testEntryT e;
    e.name = name;
    e.rd = rd;
    e.adr = `MBOX_ADR_W'($random(seed));
    e.mask = mask;
    e.badPar = badPar;
    e.nxm = nxm;
    e.sel = sel;
    e.words = words;
    tests[testCount] = e;
    testCount++;
  endtask

  // Post one request, wait for its ack, then read back the diagnostic words
  task automatic runTest(input testEntryT t);
    cur = t;
    wbAdr = t.adr;
    wbDatIn = `MBOX_WB_DAT_W'({t.badPar, t.mask});
    wbWe = !t.rd;
    wbCyc = 1'b1;
    wbStb = 1'b1;
    do @(negedge clk); while (!wbAck);
    @(posedge clk);
    #1;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    diagCheck = 1'b1;
    diagSel = 0;
    @(posedge clk);
    #1 diagSel = 1;
    @(posedge clk);
    #1 diagSel = t.sel;
    @(posedge clk);
    #1 diagCheck = 1'b0;
  endtask

  always @(posedge clk) begin
    if (reset) begin
      busCycle <= 0;
    end else begin
      busCycle <= busCycle + 1;
    end
  end

  // Memory side answers in change-coming cycles of the started phase
  always @(posedge clk) begin
    #1;
    memAcknA = 1'b0;
    memAcknB = 1'b0;
    nxmAckn = 1'b0;
    memDataValidA = 1'b0;
    memDataValidB = 1'b0;
    if ((memStartA && !respPrevA) || (memStartB && !respPrevB)) begin
      respLeft = cur.nxm ? 1 : countBits(cur.mask);
    end
    if (respLeft > 0 && ((memStartA && busCycle % 8 == 7) ||
                         (memStartB && busCycle % 8 == 3))) begin
      if (cur.nxm) begin
        nxmAckn = 1'b1;
      end else begin
        memAcknA = memStartA;
        memAcknB = memStartB;
        memDataValidA = memStartA && cur.rd;
        memDataValidB = memStartB && cur.rd;
      end
      respLeft--;
    end
    respPrevA = memStartA;
    respPrevB = memStartB;
  end

  always @(posedge clk) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout: run did not finish within %0d cycles", cycleLimit);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    clk = 1'b0;
    reset = 1'b1;
    wbCyc = 1'b0;
    wbStb = 1'b0;
    wbWe = 1'b0;
    wbAdr = '0;
    wbDatIn = '0;
    memAcknA = 1'b0;
    memAcknB = 1'b0;
    nxmAckn = 1'b0;
    memDataValidA = 1'b0;
    memDataValidB = 1'b0;
    diagSel = '0;
    diagCheck = 1'b0;
    cur = '0;
    seed = 32'h4a6ddbd5;
    // name, read, mask, bad parity, nxm, diag select, expected words
    addEntry("rd1", 1'b1, 4'b0001, 1'b0, 1'b0, 3, 1);
    addEntry("rd2", 1'b1, 4'b0101, 1'b0, 1'b0, 4, 2);
    addEntry("rd3", 1'b1, 4'b1110, 1'b0, 1'b0, 5, 3);
    addEntry("rd4", 1'b1, 4'b1111, 1'b0, 1'b0, 6, 4);
    addEntry("wr4", 1'b0, 4'b1111, 1'b0, 1'b0, 7, 0);
    addEntry("wrBadPar", 1'b0, 4'b0011, 1'b1, 1'b0, 3, 0);
    addEntry("rdBadPar", 1'b1, 4'b1000, 1'b1, 1'b0, 4, 1);
    addEntry("rdNxm", 1'b1, 4'b0110, 1'b0, 1'b1, 3, 0);
    addEntry("wrNxm", 1'b0, 4'b1001, 1'b0, 1'b1, 5, 0);
    repeat (resetCycles) @(posedge clk);
    #1;
    reset = 1'b0;
    for (int i = 0; i < numTests; i++) begin
      runTest(tests[i]);
    end
    $display("Errors: %0d value mismatches, %0d protocol errors in %0d tests",
             valueErrors, protocolErrors, numTests);
    if (valueErrors + protocolErrors == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: project.f
+incdir+rtl
rtl/mboxPkg.sv
rtl/memReqIf.sv
rtl/phaseClock.sv
rtl/memStart.sv
rtl/coreReadTracker.sv
rtl/diagMux.sv
rtl/mboxControl.sv
tb/mboxChecker.sv
tb/mboxControlTb.sv
